// ==== hdl/permute_pkg.sv ====
package permute_pkg;

  // ---------------------------------------------------------------------------
  // Matrix geometry
  // ---------------------------------------------------------------------------
  localparam int ELEM_W     = 16;
  localparam int NUM_LANES  = 8;
  localparam int LANE_IDX_W = 3;

  // Count has to reach NUM_LANES, one bit wider than a lane index
  localparam int CNT_W      = 4;

  localparam int REGID_W    = 8;

  // Flat widths for the top-level ports
  localparam int ROW_W      = NUM_LANES * ELEM_W;
  localparam int IDX_VEC_W  = NUM_LANES * LANE_IDX_W;

  // ---------------------------------------------------------------------------
  // Element, row and index types
  // ---------------------------------------------------------------------------
  typedef logic [ELEM_W-1:0] elem_t;

  // Lane 0 sits in the lowest bits
  typedef elem_t [NUM_LANES-1:0] row_t;

  typedef logic [LANE_IDX_W-1:0] lane_idx_t;

  typedef lane_idx_t [NUM_LANES-1:0] idx_vec_t;

  // Row 0 sits in the lowest bits
  typedef row_t [NUM_LANES-1:0] matrix_t;

endpackage

// ==== hdl/permute_ctrl_if.sv ====
`timescale 1ns/1ps

interface permute_ctrl_if
  import permute_pkg::*;
();

  // One-hot row write enable for a load
  logic [NUM_LANES-1:0] load_row;
  row_t                 load_data;

  // Shuffle strobe, one cycle per shuffle command
  logic                 shuffle;
  // High selects the row operation, low the column operation
  logic                 row_op;
  idx_vec_t             sel;

  modport seq (
    output load_row,
    output load_data,
    output shuffle,
    output row_op,
    output sel
  );

  modport array (
    input load_row,
    input load_data,
    input shuffle,
    input row_op,
    input sel
  );

endinterface

// ==== hdl/permute_elm.sv ====
`timescale 1ns/1ps

module permute_elm
  import permute_pkg::*;
(
  input  logic      clk,
  input  logic      resetn,
  input  logic      row_op_i,
  input  logic      shuffle_i,
  input  logic      load_i,
  input  lane_idx_t row_sel_i,
  input  lane_idx_t col_sel_i,
  input  row_t      row_src_i,
  input  row_t      col_src_i,
  input  elem_t     load_data_i,
  output elem_t     data_o
);

  elem_t row_pick;
  elem_t col_pick;
  elem_t next_data;
  elem_t data_q;

  // ---------------------------------------------------------------------------
  // Source multiplexers
  // ---------------------------------------------------------------------------

  // Element of the own row picked by lane index
  always_comb begin
    row_pick = row_src_i[row_sel_i];
  end

  // Element of the own column picked by row index
  always_comb begin
    col_pick = col_src_i[col_sel_i];
  end

  always_comb begin
    if (row_op_i) begin
      next_data = row_pick;
    end else begin
      next_data = col_pick;
    end
  end

  // ---------------------------------------------------------------------------
  // Storage
  // ---------------------------------------------------------------------------

  // Load wins over shuffle
  always_ff @(posedge clk) begin
    if (!resetn) begin
      data_q <= '0;
    end else if (load_i) begin
      data_q <= load_data_i;
    end else if (shuffle_i) begin
      data_q <= next_data;
    end
  end

  assign data_o = data_q;

endmodule

// ==== hdl/permute_array.sv ====
`timescale 1ns/1ps

module permute_array
  import permute_pkg::*;
(
  input  logic                 clk,
  input  logic                 resetn,
  permute_ctrl_if.array        ctrl,
  output matrix_t              rows_o
);

  // Stored cells, indexed [row][lane]
  wire matrix_t cells;

  // Transposed view, indexed [column][row]
  wire matrix_t cols;

  // ---------------------------------------------------------------------------
  // Column wiring
  // ---------------------------------------------------------------------------
  for (genvar c = 0; c < NUM_LANES; c++) begin : g_col
    for (genvar r = 0; r < NUM_LANES; r++) begin : g_row
      assign cols[c][r] = cells[r][c];
    end
  end

  // ---------------------------------------------------------------------------
  // Cell grid
  // ---------------------------------------------------------------------------

  // Row op: cell (i,j) takes (i, sel[j]); column op: cell (i,j) takes (sel[i], j)
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_i
    for (genvar j = 0; j < NUM_LANES; j++) begin : g_j
      permute_elm u_elm (
        .clk         (clk),
        .resetn      (resetn),
        .row_op_i    (ctrl.row_op),
        .shuffle_i   (ctrl.shuffle),
        .load_i      (ctrl.load_row[i]),
        .row_sel_i   (ctrl.sel[j]),
        .col_sel_i   (ctrl.sel[i]),
        .row_src_i   (cells[i]),
        .col_src_i   (cols[j]),
        .load_data_i (ctrl.load_data[j]),
        .data_o      (cells[i][j])
      );
    end
  end

  assign rows_o = cells;

endmodule

// ==== hdl/permute_seq.sv ====
`timescale 1ns/1ps

module permute_seq
  import permute_pkg::*;
(
  input  logic          clk,
  input  logic          resetn,
  input  logic          en_i,
  input  logic          load_i,
  input  logic          read_i,
  input  logic          row_col_op_i,
  input  idx_vec_t      row_col_num_i,
  input  row_t          a_i,
  permute_ctrl_if.seq   ctrl,
  output logic          rd_en_o,
  output lane_idx_t     rd_idx_o
);

  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_dec;
  logic             full;
  logic             empty;

  logic load_cmd;
  logic read_cmd;
  logic shuffle_cmd;
  logic load_take;
  logic read_take;

  // ---------------------------------------------------------------------------
  // Command decode
  // ---------------------------------------------------------------------------
  assign full  = (count_q == CNT_W'(NUM_LANES));
  assign empty = (count_q == '0);

  // Priority is load, then read, then shuffle
  assign load_cmd    = en_i & load_i;
  assign read_cmd    = en_i & ~load_i & read_i;
  assign shuffle_cmd = en_i & ~load_i & ~read_i;

  assign load_take = load_cmd & ~full;
  assign read_take = read_cmd & ~empty;

  // ---------------------------------------------------------------------------
  // Row counter
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!resetn) begin
      count_q <= '0;
    end else if (load_take) begin
      count_q <= count_q + CNT_W'(1);
    end else if (read_take) begin
      count_q <= count_dec;
    end
  end

  assign count_dec = count_q - CNT_W'(1);

  // ---------------------------------------------------------------------------
  // Array control and read index
  // ---------------------------------------------------------------------------

  // count_q is below NUM_LANES whenever a load is taken
  assign ctrl.load_row  = load_take ? (NUM_LANES'(1) << count_q[LANE_IDX_W-1:0]) : '0;
  assign ctrl.load_data = a_i;
  assign ctrl.shuffle   = shuffle_cmd;
  assign ctrl.row_op    = row_col_op_i;
  assign ctrl.sel       = row_col_num_i;

  // LIFO order, the last loaded row leaves first
  assign rd_en_o  = read_take;
  assign rd_idx_o = count_dec[LANE_IDX_W-1:0];

  // ---------------------------------------------------------------------------
  // Assertions
  // ---------------------------------------------------------------------------
  a_count_range: assert property (
    @(posedge clk) disable iff (!resetn)
    count_q <= CNT_W'(NUM_LANES)
  ) else $error("row count above %0d", NUM_LANES);

  a_load_row_onehot: assert property (
    @(posedge clk) disable iff (!resetn)
    $onehot0(ctrl.load_row)
  ) else $error("load_row not one-hot");

  // Loads at full and reads at empty are dropped and flagged
  a_load_at_full: assert property (
    @(posedge clk) disable iff (!resetn)
    !(load_cmd && full)
  ) else $warning("load ignored, matrix full");

  a_read_at_empty: assert property (
    @(posedge clk) disable iff (!resetn)
    !(read_cmd && empty)
  ) else $warning("read ignored, matrix empty");

endmodule

// ==== hdl/permute_wb.sv ====
`timescale 1ns/1ps

module permute_wb
  import permute_pkg::*;
(
  input  logic                 clk,
  input  logic                 resetn,
  input  matrix_t              rows_i,
  input  logic                 rd_en_i,
  input  lane_idx_t            rd_idx_i,
  input  logic [REGID_W-1:0]   dst_i,
  input  logic                 dst_we_i,
  input  logic [NUM_LANES-1:0] dst_mask_i,
  output logic                 wb_valid_o,
  output row_t                 wb_data_o,
  output logic [REGID_W-1:0]   wb_dst_o,
  output logic                 wb_we_o,
  output logic [NUM_LANES-1:0] wb_mask_o
);

  // Valid and write enable pulse for one cycle per read
  always_ff @(posedge clk) begin
    if (!resetn) begin
      wb_valid_o <= 1'b0;
      wb_we_o    <= 1'b0;
    end else begin
      wb_valid_o <= rd_en_i;
      wb_we_o    <= rd_en_i & dst_we_i;
    end
  end

  // Row and tags hold between reads
  always_ff @(posedge clk) begin
    if (!resetn) begin
      wb_data_o <= '0;
      wb_dst_o  <= '0;
      wb_mask_o <= '0;
    end else if (rd_en_i) begin
      wb_data_o <= rows_i[rd_idx_i];
      wb_dst_o  <= dst_i;
      wb_mask_o <= dst_mask_i;
    end
  end

  a_we_needs_valid: assert property (
    @(posedge clk) disable iff (!resetn)
    $rose(wb_we_o) |-> wb_valid_o
  ) else $error("wb_we_o rose without wb_valid_o");

endmodule

// ==== hdl/vec_permute_top.sv ====
`timescale 1ns/1ps

module vec_permute_top
  import permute_pkg::*;
(
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 en_i,
  input  logic                 load_i,
  input  logic                 read_i,
  input  logic                 row_col_op_i,
  input  logic [IDX_VEC_W-1:0] row_col_num_i,
  input  logic [ROW_W-1:0]     a_i,
  input  logic [REGID_W-1:0]   dst_i,
  input  logic                 dst_we_i,
  input  logic [NUM_LANES-1:0] dst_mask_i,
  output logic                 wb_valid_o,
  output logic [ROW_W-1:0]     wb_data_o,
  output logic [REGID_W-1:0]   wb_dst_o,
  output logic                 wb_we_o,
  output logic [NUM_LANES-1:0] wb_mask_o
);

  permute_ctrl_if ctrl ();

  matrix_t   rows;
  row_t      wb_row;
  logic      rd_en;
  lane_idx_t rd_idx;

  // Flat ports map lane 0 to the lowest bits
  permute_seq u_seq (
    .clk           (clk),
    .resetn        (resetn),
    .en_i          (en_i),
    .load_i        (load_i),
    .read_i        (read_i),
    .row_col_op_i  (row_col_op_i),
    .row_col_num_i (idx_vec_t'(row_col_num_i)),
    .a_i           (row_t'(a_i)),
    .ctrl          (ctrl.seq),
    .rd_en_o       (rd_en),
    .rd_idx_o      (rd_idx)
  );

  permute_array u_array (
    .clk    (clk),
    .resetn (resetn),
    .ctrl   (ctrl.array),
    .rows_o (rows)
  );

  permute_wb u_wb (
    .clk        (clk),
    .resetn     (resetn),
    .rows_i     (rows),
    .rd_en_i    (rd_en),
    .rd_idx_i   (rd_idx),
    .dst_i      (dst_i),
    .dst_we_i   (dst_we_i),
    .dst_mask_i (dst_mask_i),
    .wb_valid_o (wb_valid_o),
    .wb_data_o  (wb_row),
    .wb_dst_o   (wb_dst_o),
    .wb_we_o    (wb_we_o),
    .wb_mask_o  (wb_mask_o)
  );

  assign wb_data_o = wb_row;

endmodule

// ==== verif/tb_vec_permute.sv ====
`timescale 1ns/1ps

module tb_vec_permute
  import permute_pkg::*;
();

  localparam int K_LOAD       = 0;
  localparam int K_READ       = 1;
  localparam int K_ROW        = 2;
  localparam int K_COL        = 3;
  localparam int K_IDLE       = 4;
  localparam int MAX_CMDS     = 128;
  localparam int RESET_CYCLES = 4;

  logic                 clk;
  logic                 resetn;
  logic                 en_i;
  logic                 load_i;
  logic                 read_i;
  logic                 row_col_op_i;
  logic [IDX_VEC_W-1:0] row_col_num_i;
  logic [ROW_W-1:0]     a_i;
  logic [REGID_W-1:0]   dst_i;
  logic                 dst_we_i;
  logic [NUM_LANES-1:0] dst_mask_i;
  logic                 wb_valid_o;
  logic [ROW_W-1:0]     wb_data_o;
  logic [REGID_W-1:0]   wb_dst_o;
  logic                 wb_we_o;
  logic [NUM_LANES-1:0] wb_mask_o;

  // Command table
  int                   cmd_kind [MAX_CMDS];
  logic [ROW_W-1:0]     cmd_data [MAX_CMDS];
  logic [IDX_VEC_W-1:0] cmd_vec  [MAX_CMDS];
  logic [REGID_W-1:0]   cmd_dst  [MAX_CMDS];
  logic [NUM_LANES-1:0] cmd_mask [MAX_CMDS];
  logic                 cmd_we   [MAX_CMDS];
  int                   n_cmds;

  // Reference matrix, count and expected writeback registers
  elem_t                ref_mat [NUM_LANES][NUM_LANES];
  int                   ref_cnt;
  logic                 exp_valid;
  logic [ROW_W-1:0]     exp_data;
  logic [REGID_W-1:0]   exp_dst;
  logic                 exp_we;
  logic [NUM_LANES-1:0] exp_mask;

  int     errors;
  int     checks;
  int     cycles;
  int     cycle_limit;
  integer seed;

  vec_permute_top dut (
    .clk           (clk),
    .resetn        (resetn),
    .en_i          (en_i),
    .load_i        (load_i),
    .read_i        (read_i),
    .row_col_op_i  (row_col_op_i),
    .row_col_num_i (row_col_num_i),
    .a_i           (a_i),
    .dst_i         (dst_i),
    .dst_we_i      (dst_we_i),
    .dst_mask_i    (dst_mask_i),
    .wb_valid_o    (wb_valid_o),
    .wb_data_o     (wb_data_o),
    .wb_dst_o      (wb_dst_o),
    .wb_we_o       (wb_we_o),
    .wb_mask_o     (wb_mask_o)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycle_limit) begin
      $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Table construction
  // --------------------------------------------------------------------------
  function automatic logic [ROW_W-1:0] random_row();
    logic [ROW_W-1:0] r;
    for (int j = 0; j < NUM_LANES; j++) begin
      r[j*ELEM_W +: ELEM_W] = $random(seed);
    end
    return r;
  endfunction

  function automatic logic [IDX_VEC_W-1:0] vec8(input int l0, input int l1, input int l2,
                                                input int l3, input int l4, input int l5,
                                                input int l6, input int l7);
    return {LANE_IDX_W'(l7), LANE_IDX_W'(l6), LANE_IDX_W'(l5), LANE_IDX_W'(l4),
            LANE_IDX_W'(l3), LANE_IDX_W'(l2), LANE_IDX_W'(l1), LANE_IDX_W'(l0)};
  endfunction

  task automatic add_cmd(input int kind, input logic [ROW_W-1:0] data,
                         input logic [IDX_VEC_W-1:0] vec, input logic [REGID_W-1:0] dst,
                         input logic [NUM_LANES-1:0] mask, input logic we);
    cmd_kind[n_cmds] = kind;
    cmd_data[n_cmds] = data;
    cmd_vec[n_cmds]  = vec;
    cmd_dst[n_cmds]  = dst;
    cmd_mask[n_cmds] = mask;
    cmd_we[n_cmds]   = we;
    n_cmds++;
  endtask

  task automatic add_loads(input int n);
    for (int i = 0; i < n; i++) begin
      add_cmd(K_LOAD, random_row(), '0, '0, '0, 1'b0);
    end
  endtask

  // Tags differ per read, write enable skips every third read
  task automatic add_reads(input int n, input int first_dst);
    logic [NUM_LANES-1:0] mask;
    for (int i = 0; i < n; i++) begin
      mask = $random(seed);
      add_cmd(K_READ, random_row(), '0, REGID_W'(first_dst + i), mask, (i % 3) != 0);
    end
  endtask

  task automatic build_table();
    add_loads(8);
    add_reads(8, 8'h10);
    add_cmd(K_IDLE, '0, '0, '0, '0, 1'b0);
    add_loads(8);
    add_cmd(K_ROW, '0, vec8(3, 7, 0, 5, 1, 6, 2, 4), '0, '0, 1'b0);
    add_reads(8, 8'h20);
    add_loads(8);
    add_cmd(K_COL, '0, vec8(7, 7, 2, 0, 0, 5, 3, 3), '0, '0, 1'b0);
    add_reads(4, 8'h30);
    // Load, read and shuffle strobes with en_i low
    add_cmd(K_IDLE, ROW_W'(1), '0, '0, '0, 1'b0);
    add_cmd(K_IDLE, ROW_W'(2), '0, '0, '0, 1'b0);
    add_cmd(K_IDLE, '0, vec8(3, 2, 1, 0, 7, 6, 5, 4), '0, '0, 1'b0);
    add_cmd(K_ROW, '0, vec8(1, 1, 1, 6, 6, 0, 7, 2), '0, '0, 1'b0);
    add_reads(4, 8'h38);
    add_loads(8);
    // Ninth load must be dropped
    add_loads(1);
    add_cmd(K_COL, '0, vec8(6, 4, 2, 0, 7, 5, 3, 1), '0, '0, 1'b0);
    add_reads(8, 8'h40);
    add_reads(2, 8'h50);
    add_loads(3);
    add_reads(1, 8'h60);
    add_loads(1);
    add_reads(3, 8'h68);
    add_cmd(K_IDLE, '0, '0, '0, '0, 1'b0);
    add_cmd(K_IDLE, '0, '0, '0, '0, 1'b0);
  endtask

  // --------------------------------------------------------------------------
  // Driving, model and checks
  // --------------------------------------------------------------------------
  task automatic drive_cmd(input int k);
    en_i = (cmd_kind[k] != K_IDLE);
    // An idle entry takes load_i and read_i from data bits 0 and 1
    if (cmd_kind[k] == K_IDLE) begin
      load_i = cmd_data[k][0];
      read_i = cmd_data[k][1];
    end else begin
      load_i = (cmd_kind[k] == K_LOAD);
      read_i = (cmd_kind[k] == K_READ);
    end
    row_col_op_i  = (cmd_kind[k] == K_ROW);
    row_col_num_i = cmd_vec[k];
    a_i           = cmd_data[k];
    dst_i         = cmd_dst[k];
    dst_we_i      = cmd_we[k];
    dst_mask_i    = cmd_mask[k];
  endtask

  task automatic update_model(input int k);
    elem_t     old_mat [NUM_LANES][NUM_LANES];
    lane_idx_t src;
    exp_valid = 1'b0;
    exp_we    = 1'b0;
    old_mat   = ref_mat;
    case (cmd_kind[k])
      K_LOAD: begin
        if (ref_cnt < NUM_LANES) begin
          for (int j = 0; j < NUM_LANES; j++) begin
            ref_mat[ref_cnt][j] = cmd_data[k][j*ELEM_W +: ELEM_W];
          end
          ref_cnt++;
        end
      end
      K_READ: begin
        // Data and tags hold their last value on a read from empty
        if (ref_cnt > 0) begin
          ref_cnt--;
          for (int j = 0; j < NUM_LANES; j++) begin
            exp_data[j*ELEM_W +: ELEM_W] = ref_mat[ref_cnt][j];
          end
          exp_valid = 1'b1;
          exp_we    = cmd_we[k];
          exp_dst   = cmd_dst[k];
          exp_mask  = cmd_mask[k];
        end
      end
      K_ROW: begin
        for (int i = 0; i < NUM_LANES; i++) begin
          for (int j = 0; j < NUM_LANES; j++) begin
            src = cmd_vec[k][j*LANE_IDX_W +: LANE_IDX_W];
            ref_mat[i][j] = old_mat[i][src];
          end
        end
      end
      K_COL: begin
        for (int i = 0; i < NUM_LANES; i++) begin
          src = cmd_vec[k][i*LANE_IDX_W +: LANE_IDX_W];
          for (int j = 0; j < NUM_LANES; j++) begin
            ref_mat[i][j] = old_mat[src][j];
          end
        end
      end
      default: begin
      end
    endcase
  endtask

  task automatic compare_value(input string name, input logic [ROW_W-1:0] got,
                               input logic [ROW_W-1:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic check_outputs();
    compare_value("wb_valid_o", ROW_W'(wb_valid_o), ROW_W'(exp_valid));
    compare_value("wb_we_o", ROW_W'(wb_we_o), ROW_W'(exp_we));
    compare_value("wb_data_o", wb_data_o, exp_data);
    compare_value("wb_dst_o", ROW_W'(wb_dst_o), ROW_W'(exp_dst));
    compare_value("wb_mask_o", ROW_W'(wb_mask_o), ROW_W'(exp_mask));
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------
  initial begin
    clk           = 1'b0;
    resetn        = 1'b0;
    en_i          = 1'b0;
    load_i        = 1'b0;
    read_i        = 1'b0;
    row_col_op_i  = 1'b0;
    row_col_num_i = '0;
    a_i           = '0;
    dst_i         = '0;
    dst_we_i      = 1'b0;
    dst_mask_i    = '0;
    errors        = 0;
    checks        = 0;
    cycles        = 0;
    n_cmds        = 0;
    ref_cnt       = 0;
    seed          = 83772;
    exp_valid     = 1'b0;
    exp_data      = '0;
    exp_dst       = '0;
    exp_we        = 1'b0;
    exp_mask      = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      for (int j = 0; j < NUM_LANES; j++) begin
        ref_mat[i][j] = '0;
      end
    end

    build_table();
    cycle_limit = n_cmds + 20;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    check_outputs();

    // Outputs of command k are checked on the falling edge after it is taken
    for (int k = 0; k < n_cmds; k++) begin
      @(negedge clk);
      check_outputs();
      drive_cmd(k);
      update_model(k);
    end
    @(negedge clk);
    check_outputs();

    $display("Run finished, %0d errors in %0d checks", errors, checks);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
hdl/permute_pkg.sv
hdl/permute_ctrl_if.sv
hdl/permute_elm.sv
hdl/permute_array.sv
hdl/permute_seq.sv
hdl/permute_wb.sv
hdl/vec_permute_top.sv
verif/tb_vec_permute.sv

// ==== Bender.yml ====
package:
  name: vec_permute

sources:
  - hdl/permute_pkg.sv
  - hdl/permute_ctrl_if.sv
  - hdl/permute_elm.sv
  - hdl/permute_array.sv
  - hdl/permute_seq.sv
  - hdl/permute_wb.sv
  - hdl/vec_permute_top.sv
  - target: test
    files:
      - verif/tb_vec_permute.sv
